//--- bpu_defines.svh
`ifndef BPU_DEFINES_SVH
`define BPU_DEFINES_SVH

// datapath widths
`define BPU_XLEN              32
`define BPU_HIST_LEN          16

// direction predictor tables
`define BPU_BIMODAL_ENTRIES   512
`define BPU_TAGGED_ENTRIES    256   // per tagged table
`define BPU_TAG_WIDTH         10
`define BPU_PARTIAL_TAG_BITS  6     // upper tag bits compared on lookup

// target buffer and return stack
`define BPU_BTB_ENTRIES       256
`define BPU_BTB_TAG_WIDTH     22
`define BPU_RAS_DEPTH         64

// pc bit positions for indexing
`define BPU_BIM_IDX_LSB       1     // bimodal index pc[9:1]
`define BPU_TAG_PC_LSB        8     // tagged table tag pc[17:8]
`define BPU_BTB_IDX_LSB       2     // btb index pc[9:2]

`endif

//--- bpu_pkg.sv
package bpu_pkg;

    `include "bpu_defines.svh"

    typedef logic [`BPU_XLEN-1:0]     addr_t;
    typedef logic [`BPU_HIST_LEN-1:0] hist_t;
    typedef logic [1:0]               ctr_t;   // 2-bit saturating counter

    // control transfer opcodes
    typedef enum logic [6:0] {
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [2:0] {
        KIND_OTHER,
        KIND_BRANCH,
        KIND_JAL,
        KIND_JALR,
        KIND_RET
    } inst_kind_e;

    // which table gave the direction
    typedef enum logic [1:0] {
        PROV_BIMODAL = 2'd0,
        PROV_T0      = 2'd1,
        PROV_T1      = 2'd2
    } provider_e;

endpackage

//--- bpu_update_if.sv
`timescale 1ns/1ps

// execute stage feedback, one update per cycle with valid high
interface bpu_update_if;

    logic                valid;
    logic                taken;
    logic                mispredict;
    bpu_pkg::addr_t      pc;
    bpu_pkg::hist_t      history;      // history seen at prediction time
    bpu_pkg::provider_e  provider;
    bpu_pkg::addr_t      target;

    modport source (
        output valid, taken, mispredict, pc, history, provider, target
    );

    modport sink (
        input valid, taken, mispredict, pc, history, provider, target
    );

endinterface

//--- branch_decode.sv
`timescale 1ns/1ps
`include "bpu_defines.svh"

module branch_decode (
    input  bpu_pkg::addr_t      inst_i,
    output bpu_pkg::inst_kind_e kind_o,
    output bpu_pkg::addr_t      jal_offset_o,
    output bpu_pkg::addr_t      br_offset_o
);
    import bpu_pkg::*;

    logic [6:0] opcode;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic       link_rs1;
    logic       is_ret;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign rs1    = inst_i[19:15];

    assign link_rs1 = (rs1 == 5'd1) || (rs1 == 5'd5);   // ra or t0
    // jalr x0, 0(ra) style return
    assign is_ret = (rd == 5'd0) && link_rs1 && (inst_i[31:20] == 12'd0);

    always_comb begin
        case (opcode)
            OPC_BRANCH: kind_o = KIND_BRANCH;
            OPC_JAL:    kind_o = KIND_JAL;
            OPC_JALR:   kind_o = is_ret ? KIND_RET : KIND_JALR;
            default:    kind_o = KIND_OTHER;
        endcase
    end

    // j-immediate
    assign jal_offset_o = {{(`BPU_XLEN-20){inst_i[31]}}, inst_i[19:12], inst_i[20],
                           inst_i[30:21], 1'b0};

    // b-immediate
    assign br_offset_o = {{(`BPU_XLEN-12){inst_i[31]}}, inst_i[7], inst_i[30:25],
                          inst_i[11:8], 1'b0};

endmodule

//--- tage_predictor.sv
`timescale 1ns/1ps
`include "bpu_defines.svh"

module tage_predictor (
    input  logic                clk,
    input  logic                rst,
    input  bpu_pkg::addr_t      pc_i,
    bpu_update_if.sink          upd,
    output logic                dir_taken_o,
    output bpu_pkg::provider_e  provider_o,
    output bpu_pkg::hist_t      history_o
);
    import bpu_pkg::*;

    localparam int BIM_W  = $clog2(`BPU_BIMODAL_ENTRIES);
    localparam int TIDX_W = $clog2(`BPU_TAGGED_ENTRIES);
    localparam int TAG_W  = `BPU_TAG_WIDTH;
    localparam int PART_W = `BPU_PARTIAL_TAG_BITS;
    localparam ctr_t CTR_WEAK_NT = 2'b01;

    hist_t            global_history;
    ctr_t             bim_ctr [`BPU_BIMODAL_ENTRIES];
    ctr_t             t0_ctr  [`BPU_TAGGED_ENTRIES];
    ctr_t             t1_ctr  [`BPU_TAGGED_ENTRIES];
    logic [TAG_W-1:0] t0_tag  [`BPU_TAGGED_ENTRIES];
    logic [TAG_W-1:0] t1_tag  [`BPU_TAGGED_ENTRIES];

    logic [BIM_W-1:0]  bim_idx_l, bim_idx_u;
    logic [TIDX_W-1:0] t0_idx_l, t1_idx_l, t0_idx_u, t1_idx_u;
    logic [TAG_W-1:0]  t0_tag_l, t1_tag_l, t0_tag_u, t1_tag_u;
    logic              t0_hit, t1_hit;

    function automatic logic [BIM_W-1:0] bim_index(addr_t pc);
        return pc[`BPU_BIM_IDX_LSB +: BIM_W];
    endfunction

    function automatic logic [TIDX_W-1:0] t0_index(addr_t pc, hist_t h);
        return pc[TIDX_W-1:0] ^ h[TIDX_W-1:0];
    endfunction

    function automatic logic [TIDX_W-1:0] t1_index(addr_t pc, hist_t h);
        return pc[TIDX_W-1:0] ^ h[`BPU_HIST_LEN-1 -: TIDX_W];
    endfunction

    function automatic logic [TAG_W-1:0] t0_tag_hash(addr_t pc, hist_t h);
        return pc[`BPU_TAG_PC_LSB +: TAG_W] ^ h[`BPU_HIST_LEN-1 -: TAG_W];
    endfunction

    // low history byte, zero-extended to the tag width
    function automatic logic [TAG_W-1:0] t1_tag_hash(addr_t pc, hist_t h);
        return pc[`BPU_TAG_PC_LSB +: TAG_W] ^ {{(TAG_W-8){1'b0}}, h[7:0]};
    endfunction

    function automatic ctr_t ctr_sat(ctr_t c, logic up);
        if (up)
            return (c == 2'b11) ? c : c + 2'b01;
        else
            return (c == 2'b00) ? c : c - 2'b01;
    endfunction

    // lookup uses the live history
    assign bim_idx_l = bim_index(pc_i);
    assign t0_idx_l  = t0_index(pc_i, global_history);
    assign t1_idx_l  = t1_index(pc_i, global_history);
    assign t0_tag_l  = t0_tag_hash(pc_i, global_history);
    assign t1_tag_l  = t1_tag_hash(pc_i, global_history);

    // update uses the history returned with the feedback
    assign bim_idx_u = bim_index(upd.pc);
    assign t0_idx_u  = t0_index(upd.pc, upd.history);
    assign t1_idx_u  = t1_index(upd.pc, upd.history);
    assign t0_tag_u  = t0_tag_hash(upd.pc, upd.history);
    assign t1_tag_u  = t1_tag_hash(upd.pc, upd.history);

    assign t0_hit = t0_tag[t0_idx_l][TAG_W-1 -: PART_W] == t0_tag_l[TAG_W-1 -: PART_W];
    assign t1_hit = t1_tag[t1_idx_l][TAG_W-1 -: PART_W] == t1_tag_l[TAG_W-1 -: PART_W];

    always_comb begin
        if (t1_hit) begin   // longest history wins
            provider_o  = PROV_T1;
            dir_taken_o = t1_ctr[t1_idx_l][1];
        end else if (t0_hit) begin
            provider_o  = PROV_T0;
            dir_taken_o = t0_ctr[t0_idx_l][1];
        end else begin
            provider_o  = PROV_BIMODAL;
            dir_taken_o = bim_ctr[bim_idx_l][1];
        end
    end

    assign history_o = global_history;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            global_history <= '0;
            for (int i = 0; i < `BPU_BIMODAL_ENTRIES; i++) begin
                bim_ctr[i] <= CTR_WEAK_NT;
            end
            for (int i = 0; i < `BPU_TAGGED_ENTRIES; i++) begin
                t0_ctr[i] <= CTR_WEAK_NT;
                t1_ctr[i] <= CTR_WEAK_NT;
                t0_tag[i] <= '0;
                t1_tag[i] <= '0;
            end
        end else if (upd.valid) begin
            global_history <= {global_history[`BPU_HIST_LEN-2:0], upd.taken};
            bim_ctr[bim_idx_u] <= ctr_sat(bim_ctr[bim_idx_u], upd.taken);

            if (upd.mispredict) begin
                if (upd.provider == PROV_T1) begin
                    t1_ctr[t1_idx_u] <= upd.taken ? 2'b11 : 2'b00;   // jump to strong
                end else if (upd.provider == PROV_T0) begin
                    t0_ctr[t0_idx_u] <= upd.taken ? 2'b11 : 2'b00;
                end else if (t1_tag[t1_idx_u] != t1_tag_u) begin
                    // bimodal missed, allocate in T1 first (full-width compare)
                    t1_tag[t1_idx_u] <= t1_tag_u;
                    t1_ctr[t1_idx_u] <= upd.taken ? 2'b10 : 2'b01;
                end else if (t0_tag[t0_idx_u] != t0_tag_u) begin
                    t0_tag[t0_idx_u] <= t0_tag_u;
                    t0_ctr[t0_idx_u] <= upd.taken ? 2'b10 : 2'b01;
                end
            end else if (upd.provider == PROV_T1) begin
                t1_ctr[t1_idx_u] <= ctr_sat(t1_ctr[t1_idx_u], upd.taken);
            end else if (upd.provider == PROV_T0) begin
                t0_ctr[t0_idx_u] <= ctr_sat(t0_ctr[t0_idx_u], upd.taken);
            end
        end
    end

endmodule

//--- btb.sv
`timescale 1ns/1ps
`include "bpu_defines.svh"

module btb (
    input  logic            clk,
    input  logic            rst,
    input  bpu_pkg::addr_t  pc_i,
    bpu_update_if.sink      upd,
    output logic            hit_o,
    output bpu_pkg::addr_t  target_o
);
    import bpu_pkg::*;

    localparam int IDX_W = $clog2(`BPU_BTB_ENTRIES);
    localparam int TAG_W = `BPU_BTB_TAG_WIDTH;

    logic [TAG_W-1:0]            tag_mem    [`BPU_BTB_ENTRIES];
    addr_t                       target_mem [`BPU_BTB_ENTRIES];
    logic [`BPU_BTB_ENTRIES-1:0] valid_q;

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;
    logic             wr_en;

    assign rd_idx = pc_i[`BPU_BTB_IDX_LSB +: IDX_W];
    assign rd_tag = pc_i[`BPU_XLEN-1 -: TAG_W];      // pc[31:10]
    assign wr_idx = upd.pc[`BPU_BTB_IDX_LSB +: IDX_W];
    assign wr_tag = upd.pc[`BPU_XLEN-1 -: TAG_W];
    assign wr_en  = upd.valid && upd.taken;         // only taken feedback fills

    assign hit_o    = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    assign target_o = target_mem[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_idx]    <= wr_tag;
            target_mem[wr_idx] <= upd.target;
        end
    end

endmodule

//--- return_stack.sv
`timescale 1ns/1ps
`include "bpu_defines.svh"

module return_stack (
    input  logic            clk,
    input  logic            rst,
    input  logic            pop_i,
    input  logic            push_valid_i,
    input  bpu_pkg::addr_t  push_data_i,
    input  logic            id_stall_i,
    input  logic            ex_stall_i,
    output logic            nonempty_o,
    output bpu_pkg::addr_t  top_o
);
    import bpu_pkg::*;

    localparam int IDX_W = $clog2(`BPU_RAS_DEPTH);
    localparam int PTR_W = IDX_W + 1;     // counts 0 .. depth

    addr_t            stack_mem [`BPU_RAS_DEPTH];
    logic [PTR_W-1:0] sp;                 // next free slot
    logic [PTR_W-1:0] sp_after_pop;
    logic [PTR_W-1:0] top_ptr;
    logic             do_pop;
    logic             do_push;

    assign do_pop       = pop_i && !ex_stall_i && (sp != '0);
    assign sp_after_pop = do_pop ? sp - PTR_W'(1) : sp;

    // push lands on the slot freed by a same-cycle pop
    assign do_push = push_valid_i && !id_stall_i && !ex_stall_i &&
                     (sp_after_pop < PTR_W'(`BPU_RAS_DEPTH));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp <= '0;
        end else begin
            sp <= sp_after_pop + PTR_W'(do_push);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_mem[sp_after_pop[IDX_W-1:0]] <= push_data_i;
        end
    end

    assign top_ptr    = sp - PTR_W'(1);
    assign nonempty_o = (sp != '0);
    assign top_o      = stack_mem[top_ptr[IDX_W-1:0]];   // don't care when empty

endmodule

//--- predict_select.sv
`timescale 1ns/1ps

module predict_select (
    input  bpu_pkg::addr_t      pc_i,
    input  bpu_pkg::inst_kind_e kind_i,
    input  bpu_pkg::addr_t      jal_offset_i,
    input  bpu_pkg::addr_t      br_offset_i,
    input  logic                dir_taken_i,
    input  logic                btb_hit_i,
    input  bpu_pkg::addr_t      btb_target_i,
    input  logic                ras_nonempty_i,
    input  bpu_pkg::addr_t      ras_top_i,
    input  logic                push_valid_i,
    input  bpu_pkg::addr_t      push_data_i,
    input  bpu_pkg::inst_kind_e ex_kind_i,
    input  logic                ex_valid_i,
    input  logic                ex_taken_i,
    output logic                is_cti_o,
    output logic                pred_taken_o,
    output bpu_pkg::addr_t      pred_pc_o,
    output logic                ras_pop_o
);
    import bpu_pkg::*;

    addr_t seq_pc;
    addr_t target;
    logic  taken;

    assign seq_pc = pc_i + 32'd4;

    always_comb begin
        taken  = 1'b0;
        target = seq_pc;
        case (kind_i)
            KIND_BRANCH: begin
                taken  = dir_taken_i;
                target = btb_hit_i ? btb_target_i : pc_i + br_offset_i;
            end
            KIND_JAL: begin
                taken  = 1'b1;
                target = btb_hit_i ? btb_target_i : pc_i + jal_offset_i;
            end
            KIND_RET: begin
                if (push_valid_i) begin      // call in decode right now, bypass
                    taken  = 1'b1;
                    target = push_data_i;
                end else if (ras_nonempty_i) begin
                    taken  = 1'b1;
                    target = ras_top_i;
                end
            end
            KIND_JALR: begin
                taken  = btb_hit_i;          // no way to guess without btb
                target = btb_target_i;
            end
            default: begin
                taken  = 1'b0;
                target = seq_pc;
            end
        endcase
    end

    assign is_cti_o     = (kind_i != KIND_OTHER);
    assign pred_taken_o = taken;
    assign pred_pc_o    = taken ? target : seq_pc;

    // executed return, stall and empty checks live in the stack
    assign ras_pop_o = ex_valid_i && ex_taken_i && (ex_kind_i == KIND_RET);

endmodule

//--- bpu_top.sv
`timescale 1ns/1ps

module bpu_top (
    input  logic                clk,
    input  logic                rst,
    input  bpu_pkg::addr_t      if_pc_i,
    input  bpu_pkg::addr_t      if_inst_i,
    input  logic                ex_valid_i,
    input  logic                ex_taken_i,
    input  logic                ex_mispredict_i,
    input  bpu_pkg::addr_t      ex_pc_i,
    input  bpu_pkg::addr_t      ex_target_i,
    input  bpu_pkg::addr_t      ex_inst_i,
    input  bpu_pkg::hist_t      ex_history_i,
    input  bpu_pkg::provider_e  ex_provider_i,
    input  logic                id_push_valid_i,
    input  bpu_pkg::addr_t      id_push_data_i,
    input  logic                id_stall_i,
    input  logic                ex_stall_i,
    output logic                is_cti_o,
    output logic                pred_taken_o,
    output bpu_pkg::addr_t      pred_pc_o,
    output bpu_pkg::provider_e  pred_provider_o,
    output bpu_pkg::hist_t      history_o
);
    import bpu_pkg::*;

    inst_kind_e if_kind;
    inst_kind_e ex_kind;
    addr_t      if_jal_off;
    addr_t      if_br_off;
    logic       dir_taken;
    logic       btb_hit;
    addr_t      btb_target;
    logic       ras_nonempty;
    addr_t      ras_top;
    logic       ras_pop;

    bpu_update_if upd_if ();

    assign upd_if.valid      = ex_valid_i;
    assign upd_if.taken      = ex_taken_i;
    assign upd_if.mispredict = ex_mispredict_i;
    assign upd_if.pc         = ex_pc_i;
    assign upd_if.history    = ex_history_i;
    assign upd_if.provider   = ex_provider_i;
    assign upd_if.target     = ex_target_i;

    branch_decode if_decode (
        .inst_i       (if_inst_i),
        .kind_o       (if_kind),
        .jal_offset_o (if_jal_off),
        .br_offset_o  (if_br_off)
    );

    // only the return flag is needed from execute
    branch_decode ex_decode (
        .inst_i       (ex_inst_i),
        .kind_o       (ex_kind),
        .jal_offset_o (),
        .br_offset_o  ()
    );

    tage_predictor u_tage (
        .clk         (clk),
        .rst         (rst),
        .pc_i        (if_pc_i),
        .upd         (upd_if.sink),
        .dir_taken_o (dir_taken),
        .provider_o  (pred_provider_o),
        .history_o   (history_o)
    );

    btb u_btb (
        .clk      (clk),
        .rst      (rst),
        .pc_i     (if_pc_i),
        .upd      (upd_if.sink),
        .hit_o    (btb_hit),
        .target_o (btb_target)
    );

    return_stack u_ras (
        .clk          (clk),
        .rst          (rst),
        .pop_i        (ras_pop),
        .push_valid_i (id_push_valid_i),
        .push_data_i  (id_push_data_i),
        .id_stall_i   (id_stall_i),
        .ex_stall_i   (ex_stall_i),
        .nonempty_o   (ras_nonempty),
        .top_o        (ras_top)
    );

    predict_select u_sel (
        .pc_i           (if_pc_i),
        .kind_i         (if_kind),
        .jal_offset_i   (if_jal_off),
        .br_offset_i    (if_br_off),
        .dir_taken_i    (dir_taken),
        .btb_hit_i      (btb_hit),
        .btb_target_i   (btb_target),
        .ras_nonempty_i (ras_nonempty),
        .ras_top_i      (ras_top),
        .push_valid_i   (id_push_valid_i),
        .push_data_i    (id_push_data_i),
        .ex_kind_i      (ex_kind),
        .ex_valid_i     (ex_valid_i),
        .ex_taken_i     (ex_taken_i),
        .is_cti_o       (is_cti_o),
        .pred_taken_o   (pred_taken_o),
        .pred_pc_o      (pred_pc_o),
        .ras_pop_o      (ras_pop)
    );

endmodule

//--- tb_bpu.sv
`timescale 1ns/1ps
`include "bpu_defines.svh"

module tb_bpu;
    import bpu_pkg::*;

    localparam int K_OTHER  = 0;
    localparam int K_BRANCH = 1;
    localparam int K_JAL    = 2;
    localparam int K_JALR   = 3;
    localparam int K_RET    = 4;

    localparam logic [31:0] NOP_INST  = 32'h0000_0013;
    localparam logic [31:0] RET_INST  = 32'h0000_8067;   // jalr x0, 0(ra)
    localparam logic [31:0] JALR_INST = 32'h0003_00e7;   // jalr ra, 0(t1)

    // reset, directed and random phases, closing cycles
    localparam int STIM_CYCLES = 3 + 3 + 3 + 301 + 10 + 5 + 2;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;

    logic clk, rst;
    addr_t if_pc_i, if_inst_i;
    logic ex_valid_i, ex_taken_i, ex_mispredict_i;
    addr_t ex_pc_i, ex_target_i, ex_inst_i;
    hist_t ex_history_i;
    provider_e ex_provider_i;
    logic id_push_valid_i, id_stall_i, ex_stall_i;
    addr_t id_push_data_i;
    logic is_cti_o, pred_taken_o;
    addr_t pred_pc_o;
    provider_e pred_provider_o;
    hist_t history_o;

    // model state
    logic [1:0]  m_bim [`BPU_BIMODAL_ENTRIES];
    logic [1:0]  m_t0c [`BPU_TAGGED_ENTRIES];
    logic [1:0]  m_t1c [`BPU_TAGGED_ENTRIES];
    logic [9:0]  m_t0t [`BPU_TAGGED_ENTRIES];
    logic [9:0]  m_t1t [`BPU_TAGGED_ENTRIES];
    logic        m_bv [`BPU_BTB_ENTRIES];
    logic [21:0] m_btag [`BPU_BTB_ENTRIES];
    logic [31:0] m_btgt [`BPU_BTB_ENTRIES];
    logic [31:0] m_ras [`BPU_RAS_DEPTH];
    logic [6:0]  m_sp;
    logic [15:0] m_hist;

    logic        last_taken;   // model prediction of the previous fetch
    provider_e   last_prov;
    logic [15:0] last_hist;
    logic [31:0] rng_state;
    int n_errors;
    int n_checks;
    int cycle_cnt;

    bpu_top dut0 (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic int inst_kind(input logic [31:0] inst);
        if (inst[6:0] == 7'h63)
            return K_BRANCH;
        if (inst[6:0] == 7'h6f)
            return K_JAL;
        if (inst[6:0] == 7'h67) begin
            if (inst[11:7] == 5'd0 && (inst[19:15] == 5'd1 || inst[19:15] == 5'd5) &&
                inst[31:20] == 12'd0)
                return K_RET;
            return K_JALR;
        end
        return K_OTHER;
    endfunction

    function automatic logic [31:0] b_offset(input logic [31:0] i);
        return {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] j_offset(input logic [31:0] i);
        return {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
    endfunction

    function automatic logic [1:0] sat2(input logic [1:0] c, input logic up);
        if (up)
            return (c == 2'd3) ? c : c + 2'd1;
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    function automatic void predict_ref(input logic [31:0] pc, input logic [31:0] inst,
                                        input logic pv, input logic [31:0] pd,
                                        output logic cti, output logic tk,
                                        output logic [31:0] npc, output provider_e prov);
        int kind;
        logic [7:0] i0, i1;
        logic [9:0] g0, g1;
        logic dir, hit;
        logic [31:0] tgt;
        kind = inst_kind(inst);
        i0 = pc[7:0] ^ m_hist[7:0];
        i1 = pc[7:0] ^ m_hist[15:8];
        g0 = pc[17:8] ^ m_hist[15:6];
        g1 = pc[17:8] ^ {2'b00, m_hist[7:0]};
        if (m_t1t[i1][9:4] == g1[9:4]) begin
            prov = PROV_T1;
            dir  = m_t1c[i1][1];
        end else if (m_t0t[i0][9:4] == g0[9:4]) begin
            prov = PROV_T0;
            dir  = m_t0c[i0][1];
        end else begin
            prov = PROV_BIMODAL;
            dir  = m_bim[pc[9:1]][1];
        end
        hit = m_bv[pc[9:2]] && (m_btag[pc[9:2]] == pc[31:10]);
        tk  = 1'b0;
        tgt = pc + 32'd4;
        case (kind)
            K_BRANCH: begin
                tk  = dir;
                tgt = hit ? m_btgt[pc[9:2]] : pc + b_offset(inst);
            end
            K_JAL: begin
                tk  = 1'b1;
                tgt = hit ? m_btgt[pc[9:2]] : pc + j_offset(inst);
            end
            K_RET: begin
                if (pv) begin
                    tk  = 1'b1;
                    tgt = pd;
                end else if (m_sp != 7'd0) begin
                    tk  = 1'b1;
                    tgt = m_ras[m_sp[5:0] - 6'd1];
                end
            end
            K_JALR: begin
                tk  = hit;
                tgt = m_btgt[pc[9:2]];
            end
            default: tk = 1'b0;
        endcase
        cti = (kind != K_OTHER);
        npc = tk ? tgt : pc + 32'd4;
    endfunction

    function void model_reset();
        m_hist = '0;
        m_sp   = '0;
        foreach (m_bim[i]) m_bim[i] = 2'd1;
        foreach (m_t0c[i]) begin
            m_t0c[i] = 2'd1;
            m_t1c[i] = 2'd1;
            m_t0t[i] = '0;
            m_t1t[i] = '0;
        end
        foreach (m_bv[i]) m_bv[i] = 1'b0;
    endfunction

    // applies the feedback and stack inputs that the DUT takes at the next edge
    function automatic void apply_update();
        logic [7:0] i0, i1;
        logic [9:0] g0, g1;
        logic [6:0] sp_a;
        i0 = ex_pc_i[7:0] ^ ex_history_i[7:0];
        i1 = ex_pc_i[7:0] ^ ex_history_i[15:8];
        g0 = ex_pc_i[17:8] ^ ex_history_i[15:6];
        g1 = ex_pc_i[17:8] ^ {2'b00, ex_history_i[7:0]};
        sp_a = m_sp;
        if (ex_valid_i) begin
            m_bim[ex_pc_i[9:1]] = sat2(m_bim[ex_pc_i[9:1]], ex_taken_i);
            if (ex_mispredict_i) begin
                if (ex_provider_i == PROV_T1) begin
                    m_t1c[i1] = ex_taken_i ? 2'd3 : 2'd0;
                end else if (ex_provider_i == PROV_T0) begin
                    m_t0c[i0] = ex_taken_i ? 2'd3 : 2'd0;
                end else if (m_t1t[i1] != g1) begin
                    m_t1t[i1] = g1;
                    m_t1c[i1] = ex_taken_i ? 2'd2 : 2'd1;
                end else if (m_t0t[i0] != g0) begin
                    m_t0t[i0] = g0;
                    m_t0c[i0] = ex_taken_i ? 2'd2 : 2'd1;
                end
            end else if (ex_provider_i == PROV_T1) begin
                m_t1c[i1] = sat2(m_t1c[i1], ex_taken_i);
            end else if (ex_provider_i == PROV_T0) begin
                m_t0c[i0] = sat2(m_t0c[i0], ex_taken_i);
            end
            if (ex_taken_i) begin
                m_bv[ex_pc_i[9:2]]   = 1'b1;
                m_btag[ex_pc_i[9:2]] = ex_pc_i[31:10];
                m_btgt[ex_pc_i[9:2]] = ex_target_i;
            end
            m_hist = {m_hist[14:0], ex_taken_i};
        end
        // pop first so a push lands on the freed slot
        if (ex_valid_i && ex_taken_i && !ex_stall_i && inst_kind(ex_inst_i) == K_RET &&
            sp_a != 7'd0)
            sp_a = sp_a - 7'd1;
        if (id_push_valid_i && !id_stall_i && !ex_stall_i && sp_a < 7'd64) begin
            m_ras[sp_a[5:0]] = id_push_data_i;
            sp_a = sp_a + 7'd1;
        end
        m_sp = sp_a;
    endfunction

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        logic e_cti, e_tk;
        logic [31:0] e_pc;
        provider_e e_prov;
        if (rst) begin
            model_reset();
        end else begin
            predict_ref(if_pc_i, if_inst_i, id_push_valid_i, id_push_data_i,
                        e_cti, e_tk, e_pc, e_prov);
            n_checks++;
            if (is_cti_o !== e_cti) begin
                $display("Mismatch is_cti_o: got %h expected %h", is_cti_o, e_cti);
                n_errors++;
            end
            if (pred_taken_o !== e_tk) begin
                $display("Mismatch pred_taken_o: got %h expected %h", pred_taken_o, e_tk);
                n_errors++;
            end
            if (pred_pc_o !== e_pc) begin
                $display("Mismatch pred_pc_o: got %h expected %h", pred_pc_o, e_pc);
                n_errors++;
            end
            if (pred_provider_o !== e_prov) begin
                $display("Mismatch pred_provider_o: got %h expected %h", pred_provider_o, e_prov);
                n_errors++;
            end
            if (history_o !== m_hist) begin
                $display("Mismatch history_o: got %h expected %h", history_o, m_hist);
                n_errors++;
            end
            last_taken = e_tk;
            last_prov  = e_prov;
            last_hist  = m_hist;
            apply_update();
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // new fetch with side inputs back to idle
    task automatic begin_cycle(input logic [31:0] pc, input logic [31:0] inst);
        @(posedge clk);
        if_pc_i         <= pc;
        if_inst_i       <= inst;
        ex_valid_i      <= 1'b0;
        ex_taken_i      <= 1'b0;
        ex_mispredict_i <= 1'b0;
        id_push_valid_i <= 1'b0;
        id_stall_i      <= 1'b0;
        ex_stall_i      <= 1'b0;
    endtask

    task automatic send_feedback(input logic [31:0] pc, input logic [31:0] inst,
                                 input logic tk, input logic mis, input logic [15:0] h,
                                 input provider_e prov, input logic [31:0] tgt);
        ex_valid_i      <= 1'b1;
        ex_taken_i      <= tk;
        ex_mispredict_i <= mis;
        ex_pc_i         <= pc;
        ex_inst_i       <= inst;
        ex_history_i    <= h;
        ex_provider_i   <= prov;
        ex_target_i     <= tgt;
    endtask

    task automatic send_push(input logic [31:0] data, input logic ids, input logic exs);
        id_push_valid_i <= 1'b1;
        id_push_data_i  <= data;
        id_stall_i      <= ids;
        ex_stall_i      <= exs;
    endtask

    initial begin
        logic [31:0] r, r2, pc, inst, prev_pc, prev_inst;
        logic tk;
        clk = 1'b0;
        rst = 1'b1;
        if_pc_i = '0;
        if_inst_i = '0;
        ex_valid_i = 1'b0;
        ex_taken_i = 1'b0;
        ex_mispredict_i = 1'b0;
        ex_pc_i = '0;
        ex_target_i = '0;
        ex_inst_i = '0;
        ex_history_i = '0;
        ex_provider_i = PROV_BIMODAL;
        id_push_valid_i = 1'b0;
        id_push_data_i = '0;
        id_stall_i = 1'b0;
        ex_stall_i = 1'b0;
        rng_state = 32'd21;
        n_errors = 0;
        n_checks = 0;
        cycle_cnt = 0;
        prev_pc = '0;
        prev_inst = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // reset state with beq +0x20, jal +0x40 and nop
        begin_cycle(32'h0000_0100, 32'h0200_0063);
        begin_cycle(32'h0000_0200, 32'h0400_00ef);
        begin_cycle(32'h0000_0300, NOP_INST);

        // btb miss, fill, then hit
        begin_cycle(32'h0000_3000, JALR_INST);
        begin_cycle(32'h0000_0300, NOP_INST);
        send_feedback(32'h0000_3000, JALR_INST, 1'b1, 1'b1, last_hist, last_prov, 32'h0000_5550);
        begin_cycle(32'h0000_3000, JALR_INST);

        // random branches with feedback one cycle behind the fetch
        for (int i = 0; i <= 300; i++) begin
            r = next_rand();
            pc = 32'h0000_4000 | {18'd0, r[5:4], 6'd0, r[3:0], 2'd0};
            inst = {r[31:7], 7'b1100011};
            if (i < 300)
                begin_cycle(pc, inst);
            else
                begin_cycle(32'h0000_0300, NOP_INST);
            if (i > 0) begin
                r2 = next_rand();
                tk = prev_pc[2] ? (r2[2:0] != 3'd0) : (r2[1:0] == 2'd0);
                send_feedback(prev_pc, prev_inst, tk, tk != last_taken, last_hist, last_prov,
                              prev_pc + b_offset(prev_inst));
            end
            prev_pc = pc;
            prev_inst = inst;
        end

        // three calls, then returns in lifo order
        for (int i = 0; i < 3; i++) begin
            begin_cycle(32'h0000_0300, NOP_INST);
            send_push(32'h0000_1004 + 32'h100 * i, 1'b0, 1'b0);
        end
        for (int i = 0; i < 3; i++) begin
            begin_cycle(32'h0000_6000 + 32'h10 * i, RET_INST);
            begin_cycle(32'h0000_0300, NOP_INST);
            send_feedback(32'h0000_6000 + 32'h10 * i, RET_INST, 1'b1, 1'b0, last_hist,
                          last_prov, 32'h0000_1204 - 32'h100 * i);
        end
        begin_cycle(32'h0000_6100, RET_INST);    // empty stack

        // bypass of a same-cycle push, then pop it again
        begin_cycle(32'h0000_6200, RET_INST);
        send_push(32'h0000_7777, 1'b0, 1'b0);
        begin_cycle(32'h0000_0300, NOP_INST);
        send_feedback(32'h0000_6200, RET_INST, 1'b1, 1'b0, last_hist, last_prov, 32'h7777);

        // stalled pushes are dropped
        begin_cycle(32'h0000_0300, NOP_INST);
        send_push(32'h0000_8888, 1'b1, 1'b0);
        begin_cycle(32'h0000_0300, NOP_INST);
        send_push(32'h0000_9999, 1'b0, 1'b1);
        begin_cycle(32'h0000_6300, RET_INST);

        begin_cycle(32'h0000_0300, NOP_INST);
        @(posedge clk);
        $display("checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
bpu_pkg.sv
bpu_update_if.sv
branch_decode.sv
tage_predictor.sv
btb.sv
return_stack.sv
predict_select.sv
bpu_top.sv
tb_bpu.sv

//--- run.sh
#!/bin/bash
# build and run the bpu testbench with verilator
rm -rf obj_dir
verilator --binary --timing -f vlog.f --top-module tb_bpu -o sim_bpu > build.log 2>&1 \
    && ./obj_dir/sim_bpu > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
